// File: project.f
rv_exec_pkg.sv
rv_alu.sv
rv_branch_unit.sv
rv_exu.sv
rv_op_queue.sv
rv_result_reg.sv
rv_exec_top.sv
tb_rv_exec_asserts.sv
tb_rv_checker.sv
tb_rv_exec.sv

// File: run.sh
#!/bin/sh
# builds the execute stage testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_rv_exec -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

// File: rv_alu.sv
// 64-bit alu with rv64 word-op handling, gives zero and less flags to the branch logic
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  wire rv_exec_pkg::xlen_t   i_src_a,
  input  wire rv_exec_pkg::xlen_t   i_src_b,
  input  wire rv_exec_pkg::alu_op_e i_alu_op,
  input  wire                       i_word_op,
  output rv_exec_pkg::xlen_t        o_result,
  output logic                      o_zero,
  output logic                      o_less
);

  rv_exec_pkg::xlen_t a;
  rv_exec_pkg::xlen_t b;
  rv_exec_pkg::xlen_t raw;
  logic [5:0]         shamt;
  logic [31:0]        sra_w;

  // word ops see only the low halves, zero extended
  assign a     = i_word_op ? {32'b0, i_src_a[31:0]} : i_src_a;
  assign b     = i_word_op ? {32'b0, i_src_b[31:0]} : i_src_b;
  assign shamt = i_word_op ? {1'b0, b[4:0]} : b[5:0];
  assign sra_w = $signed(a[31:0]) >>> shamt[4:0]; // sraw needs bit 31 as sign

  always_comb begin
    raw = '0;
    unique case (i_alu_op)
      rv_exec_pkg::ADD:    raw = a + b;
      rv_exec_pkg::SUB:    raw = a - b;
      rv_exec_pkg::SLL:    raw = a << shamt;
      rv_exec_pkg::SLT:    raw = {63'b0, $signed(a) < $signed(b)};
      rv_exec_pkg::SLTU:   raw = {63'b0, a < b};
      rv_exec_pkg::XOR:    raw = a ^ b;
      rv_exec_pkg::SRL:    raw = a >> shamt;
      rv_exec_pkg::SRA: begin
        if (i_word_op) begin
          raw = {32'b0, sra_w};
        end else begin
          raw = $signed(a) >>> shamt;
        end
      end
      rv_exec_pkg::OR:     raw = a | b;
      rv_exec_pkg::AND:    raw = a & b;
      rv_exec_pkg::COPY_B: raw = b; // lui
      default:             raw = '0;
    endcase
  end

  assign o_result = i_word_op ? {{32{raw[31]}}, raw[31:0]} : raw;
  assign o_zero   = o_result == '0;
  assign o_less   = (i_alu_op == rv_exec_pkg::SLT || i_alu_op == rv_exec_pkg::SLTU) ?
                    o_result[0] : 1'b0;

endmodule

`default_nettype wire

// File: rv_branch_unit.sv
// next-pc logic for jumps and conditional branches, driven by the alu flags
`timescale 1ns/1ps
`default_nettype none

module rv_branch_unit (
  input  wire rv_exec_pkg::xlen_t   i_pc,
  input  wire rv_exec_pkg::xlen_t   i_rs1,
  input  wire rv_exec_pkg::xlen_t   i_imm,
  input  wire rv_exec_pkg::branch_e i_branch,
  input  wire                       i_zero,
  input  wire                       i_less,
  output rv_exec_pkg::xlen_t        o_next_pc
);

  logic taken;

  always_comb begin
    unique case (i_branch)
      rv_exec_pkg::BR_EQ: taken = i_zero; // alu does sub
      rv_exec_pkg::BR_NE: taken = !i_zero;
      rv_exec_pkg::BR_LT: taken = i_less;
      rv_exec_pkg::BR_GE: taken = !i_less;
      default:            taken = 1'b0;
    endcase
  end

  always_comb begin
    if (i_branch == rv_exec_pkg::BR_JAL || taken) begin
      o_next_pc = i_pc + i_imm;
    end else if (i_branch == rv_exec_pkg::BR_JALR) begin
      o_next_pc = (i_rs1 + i_imm) & ~rv_exec_pkg::xlen_t'(1);
    end else begin
      o_next_pc = i_pc + rv_exec_pkg::xlen_t'(4);
    end
  end

endmodule

`default_nettype wire

// File: rv_exec_pkg.sv
// shared widths, enums and operation/result structs for the rv64 execute stage, used by scoped name
`default_nettype none

package rv_exec_pkg;

  localparam int XLEN           = 64;
  localparam int OP_QUEUE_DEPTH = 4; // also the upstream credits after reset

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [3:0]      tag_t;
  typedef logic [2:0]      cnt_t; // credit count or queue fill

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, COPY_B
  } alu_op_e;

  typedef enum logic [1:0] {
    B_RS2  = 2'b00,
    B_IMM  = 2'b01,
    B_FOUR = 2'b10
  } b_sel_e;

  // lt/ge take the alu less flag, slt or sltu picks the signedness
  typedef enum logic [2:0] {
    BR_NONE, BR_JAL, BR_JALR, BR_EQ, BR_NE, BR_LT, BR_GE
  } branch_e;

  typedef enum logic [2:0] {
    LB  = 3'b000,
    LBU = 3'b001,
    LH  = 3'b010,
    LHU = 3'b011,
    LW  = 3'b100,
    LWU = 3'b101,
    LD  = 3'b110
  } mem_op_e;

  typedef enum logic [1:0] {
    CSR_NONE, CSR_RW, CSR_RS
  } csr_op_e;

  typedef struct packed {
    xlen_t   rs1;
    xlen_t   rs2;
    xlen_t   imm;
    xlen_t   pc;
    xlen_t   sys_pc;    // trap/return target
    xlen_t   rdata;     // load data, already read
    xlen_t   csr_rdata;
    logic    a_sel_pc;
    b_sel_e  b_sel;
    alu_op_e alu_op;
    logic    word_op;
    branch_e branch;
    mem_op_e mem_op;
    logic    mem_to_reg;
    logic    sel_csr;
    csr_op_e csr_op;
    logic    sys_change_pc;
    logic    ebreak;
    logic    illegal;
    tag_t    tag;
  } exec_op_t;

  typedef struct packed {
    xlen_t alu_result;
    xlen_t next_pc;
    xlen_t gpr_wdata;
    xlen_t csr_wdata;
    logic  halt;
    logic  abort;
    tag_t  tag;
  } exec_res_t;

endpackage

`default_nettype wire

// File: rv_exec_top.sv
// standalone execute stage, queue and execute unit feeding the result register
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top (
  input  wire                        i_clk,
  input  wire                        i_arst_n,
  input  wire                        i_op_valid,
  input  wire rv_exec_pkg::exec_op_t i_op,
  output logic                       o_op_credit,
  input  wire                        i_res_credit,
  output logic                       o_res_valid,
  output rv_exec_pkg::exec_res_t     o_res
);

  rv_exec_pkg::exec_op_t  w_head;
  rv_exec_pkg::exec_res_t w_res;
  logic                   w_head_valid;
  logic                   w_pop;

  rv_op_queue u_op_queue (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_op_valid  (i_op_valid),
    .i_op        (i_op),
    .i_pop       (w_pop),
    .o_head      (w_head),
    .o_head_valid(w_head_valid),
    .o_op_credit (o_op_credit)
  );

  rv_exu u_exu (
    .i_op (w_head),
    .o_res(w_res)
  );

  rv_result_reg u_result_reg (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_head_valid(w_head_valid),
    .i_res       (w_res),
    .i_res_credit(i_res_credit),
    .o_pop       (w_pop),
    .o_res_valid (o_res_valid),
    .o_res       (o_res)
  );

endmodule

`default_nettype wire

// File: rv_exu.sv
// combinational execute unit, turns one decoded operation into its result fields
`timescale 1ns/1ps
`default_nettype none

module rv_exu (
  input  wire rv_exec_pkg::exec_op_t i_op,
  output rv_exec_pkg::exec_res_t     o_res
);

  rv_exec_pkg::xlen_t src_a;
  rv_exec_pkg::xlen_t src_b;
  rv_exec_pkg::xlen_t alu_result;
  rv_exec_pkg::xlen_t branch_pc;
  rv_exec_pkg::xlen_t load_data;
  logic               zero;
  logic               less;

  always_comb begin
    src_a = i_op.a_sel_pc ? i_op.pc : i_op.rs1;
    if (i_op.word_op) begin
      src_a = {32'b0, src_a[31:0]};
    end
  end

  always_comb begin
    unique case (i_op.b_sel)
      rv_exec_pkg::B_RS2:  src_b = i_op.rs2;
      rv_exec_pkg::B_IMM:  src_b = i_op.imm;
      rv_exec_pkg::B_FOUR: src_b = rv_exec_pkg::xlen_t'(4); // link address
      default:             src_b = '0;
    endcase
  end

  rv_alu u_alu (
    .i_src_a  (src_a),
    .i_src_b  (src_b),
    .i_alu_op (i_op.alu_op),
    .i_word_op(i_op.word_op),
    .o_result (alu_result),
    .o_zero   (zero),
    .o_less   (less)
  );

  rv_branch_unit u_branch_unit (
    .i_pc     (i_op.pc),
    .i_rs1    (i_op.rs1),
    .i_imm    (i_op.imm),
    .i_branch (i_op.branch),
    .i_zero   (zero),
    .i_less   (less),
    .o_next_pc(branch_pc)
  );

  // load extension
  always_comb begin
    unique case (i_op.mem_op)
      rv_exec_pkg::LB:  load_data = {{56{i_op.rdata[7]}}, i_op.rdata[7:0]};
      rv_exec_pkg::LBU: load_data = {56'b0, i_op.rdata[7:0]};
      rv_exec_pkg::LH:  load_data = {{48{i_op.rdata[15]}}, i_op.rdata[15:0]};
      rv_exec_pkg::LHU: load_data = {48'b0, i_op.rdata[15:0]};
      rv_exec_pkg::LW:  load_data = {{32{i_op.rdata[31]}}, i_op.rdata[31:0]};
      rv_exec_pkg::LWU: load_data = {32'b0, i_op.rdata[31:0]};
      default:          load_data = i_op.rdata;
    endcase
  end

  always_comb begin
    o_res.alu_result = alu_result;
    o_res.next_pc    = i_op.sys_change_pc ? i_op.sys_pc : branch_pc;
    o_res.gpr_wdata  = i_op.mem_to_reg ? load_data : (i_op.sel_csr ? i_op.rs2 : alu_result);
    unique case (i_op.csr_op)
      rv_exec_pkg::CSR_RW: o_res.csr_wdata = i_op.rs1;
      rv_exec_pkg::CSR_RS: o_res.csr_wdata = i_op.csr_rdata | i_op.rs1;
      default:             o_res.csr_wdata = '0;
    endcase
    o_res.halt  = i_op.ebreak;  // simulator ends the run
    o_res.abort = i_op.illegal;
    o_res.tag   = i_op.tag;
  end

endmodule

`default_nettype wire

// File: rv_op_queue.sv
// in-order operation FIFO in front of the execute unit, hands back one upstream credit per pop
`timescale 1ns/1ps
`default_nettype none

module rv_op_queue (
  input  wire                        i_clk,
  input  wire                        i_arst_n,
  input  wire                        i_op_valid,
  input  wire rv_exec_pkg::exec_op_t i_op,
  input  wire                        i_pop,
  output rv_exec_pkg::exec_op_t      o_head,
  output logic                       o_head_valid,
  output logic                       o_op_credit
);

  typedef logic [$clog2(rv_exec_pkg::OP_QUEUE_DEPTH)-1:0] ptr_t;

  rv_exec_pkg::exec_op_t mem [rv_exec_pkg::OP_QUEUE_DEPTH];
  ptr_t                  wr_ptr;
  ptr_t                  rd_ptr;
  rv_exec_pkg::cnt_t     count;
  logic                  full;
  logic                  push;
  logic                  pop;

  assign full = count == rv_exec_pkg::cnt_t'(rv_exec_pkg::OP_QUEUE_DEPTH);
  assign push = i_op_valid && !full; // upstream credits keep this from dropping
  assign pop  = i_pop && o_head_valid;

  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_op;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_t'(rv_exec_pkg::OP_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_t'(rv_exec_pkg::OP_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + rv_exec_pkg::cnt_t'(push) - rv_exec_pkg::cnt_t'(pop);
    end
  end

  assign o_head       = mem[rd_ptr];
  assign o_head_valid = count != '0;
  assign o_op_credit  = i_pop;

endmodule

`default_nettype wire

// File: rv_result_reg.sv
// output register, spends a downstream credit for each result it pulls from the queue
`timescale 1ns/1ps
`default_nettype none

module rv_result_reg (
  input  wire                         i_clk,
  input  wire                         i_arst_n,
  input  wire                         i_head_valid,
  input  wire rv_exec_pkg::exec_res_t i_res,
  input  wire                         i_res_credit,
  output logic                        o_pop,
  output logic                        o_res_valid,
  output rv_exec_pkg::exec_res_t      o_res
);

  rv_exec_pkg::cnt_t credits;

  assign o_pop = i_head_valid && (credits != '0);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      credits     <= '0;
      o_res_valid <= 1'b0;
    end else begin
      // return and spend may land together
      credits     <= credits + rv_exec_pkg::cnt_t'(i_res_credit) - rv_exec_pkg::cnt_t'(o_pop);
      o_res_valid <= o_pop;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_pop) begin
      o_res <= i_res;
    end
  end

endmodule

`default_nettype wire

// File: tb_rv_checker.sv
// result checker for the execute stage testbench, compares each result with the table entry of its tag
`timescale 1ns/1ps
`default_nettype none

module tb_rv_checker (
  input  wire                         i_clk,
  input  wire                         i_arst_n,
  input  wire                         i_res_valid,
  input  wire rv_exec_pkg::exec_res_t i_res,
  input  var rv_exec_pkg::exec_res_t  i_expected [1 << $bits(rv_exec_pkg::tag_t)],
  output int                          o_n_seen,
  output int                          o_n_pass,
  output int                          o_n_fail
);

  rv_exec_pkg::exec_res_t exp_res;
  int                     errs;

  function automatic int check_field(input string name, input rv_exec_pkg::xlen_t want,
                                     input rv_exec_pkg::xlen_t got);
    if (want !== got) begin
      $display("FAIL %0t %s expected %h actual %h", $time, name, want, got);
      return 1;
    end
    return 0;
  endfunction

  always @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_n_seen <= 0;
      o_n_pass <= 0;
      o_n_fail <= 0;
    end else if (i_res_valid) begin
      exp_res = i_expected[i_res.tag];
      // n-th result must carry tag n
      errs = check_field("tag", rv_exec_pkg::xlen_t'(rv_exec_pkg::tag_t'(o_n_seen)),
                         rv_exec_pkg::xlen_t'(i_res.tag));
      errs += check_field("alu_result", exp_res.alu_result, i_res.alu_result);
      errs += check_field("next_pc", exp_res.next_pc, i_res.next_pc);
      errs += check_field("gpr_wdata", exp_res.gpr_wdata, i_res.gpr_wdata);
      errs += check_field("csr_wdata", exp_res.csr_wdata, i_res.csr_wdata);
      errs += check_field("halt", rv_exec_pkg::xlen_t'(exp_res.halt),
                          rv_exec_pkg::xlen_t'(i_res.halt));
      errs += check_field("abort", rv_exec_pkg::xlen_t'(exp_res.abort),
                          rv_exec_pkg::xlen_t'(i_res.abort));
      if (errs == 0) begin
        $display("op %0d: ok", i_res.tag);
        o_n_pass <= o_n_pass + 1;
      end else begin
        $display("op %0d: %0d field(s) wrong", i_res.tag, errs);
        o_n_fail <= o_n_fail + 1;
      end
      o_n_seen <= o_n_seen + 1;
    end
  end

endmodule

`default_nettype wire

// File: tb_rv_exec.sv
// testbench for the execute stage, feeds the op table under credit flow control and reports
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec;

  localparam int N_TAGS      = 1 << $bits(rv_exec_pkg::tag_t);
  localparam int N_TESTS     = 16;
  localparam int HOLD_CYCLES = 12; // no downstream credit at first
  localparam int MAX_CYCLES  = 16 * N_TESTS + 50;

  logic                   clk;
  logic                   arst_n;
  logic                   op_valid;
  rv_exec_pkg::exec_op_t  op;
  logic                   op_credit;
  logic                   res_credit;
  logic                   res_valid;
  rv_exec_pkg::exec_res_t res;

  rv_exec_pkg::exec_op_t  ops [N_TAGS];
  rv_exec_pkg::exec_res_t expected [N_TAGS];
  rv_exec_pkg::exec_op_t  cur;
  int                     n_built;
  int                     n_seen;
  int                     n_pass;
  int                     n_fail;
  int                     tb_errors;
  int                     up_credits;
  int                     credit_seen;
  int                     given;
  int                     sent;
  int                     hold_left;
  int                     cycles = 0;
  logic [31:0]            lcg_state;

  rv_exec_top i_dut (
    .i_clk       (clk),
    .i_arst_n    (arst_n),
    .i_op_valid  (op_valid),
    .i_op        (op),
    .o_op_credit (op_credit),
    .i_res_credit(res_credit),
    .o_res_valid (res_valid),
    .o_res       (res)
  );

  tb_rv_checker u_checker (
    .i_clk      (clk),
    .i_arst_n   (arst_n),
    .i_res_valid(res_valid),
    .i_res      (res),
    .i_expected (expected),
    .o_n_seen   (n_seen),
    .o_n_pass   (n_pass),
    .o_n_fail   (n_fail)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, %0d of %0d results arrived", cycles, n_seen, N_TESTS);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic rv_exec_pkg::exec_op_t default_op();
    rv_exec_pkg::exec_op_t d;
    d    = '0; // add, rs2 operand, no branch, no csr
    d.pc = 64'h1000;
    return d;
  endfunction

  // stores cur with its expected result, then starts a fresh op
  task automatic add_test(input rv_exec_pkg::xlen_t alu, input rv_exec_pkg::xlen_t npc,
                          input rv_exec_pkg::xlen_t gpr, input rv_exec_pkg::xlen_t csr,
                          input logic exp_halt, input logic exp_abort);
    cur.tag           = rv_exec_pkg::tag_t'(n_built);
    ops[n_built]      = cur;
    expected[n_built] = '{alu_result: alu, next_pc: npc, gpr_wdata: gpr, csr_wdata: csr,
                          halt: exp_halt, abort: exp_abort, tag: cur.tag};
    n_built++;
    cur = default_op();
  endtask

  // one cycle of credit bookkeeping, returns just after the falling edge
  task automatic tick();
    @(negedge clk);
    up_credits += credit_seen; // that pop happened on the last rising edge
    credit_seen = op_credit ? 1 : 0;
    res_credit  = 1'b0;
    if (hold_left > 0) begin
      hold_left--;
      if (op_credit) begin
        $display("credit returned at %0t while no downstream credit was given", $time);
        tb_errors++;
      end
      if (hold_left == 0 && sent != rv_exec_pkg::OP_QUEUE_DEPTH) begin
        $display("FAIL %0t sent_ops expected %0d actual %0d", $time,
                 rv_exec_pkg::OP_QUEUE_DEPTH, sent);
        tb_errors++;
      end else if (hold_left == 0) begin
        $display("back-pressure: upstream held at %0d ops", sent);
      end
    end else begin
      lcg_state = lcg_next(lcg_state);
      if (lcg_state[16] && given < N_TESTS && given - n_seen < rv_exec_pkg::OP_QUEUE_DEPTH) begin
        res_credit = 1'b1;
        given++;
      end
    end
  endtask

  initial begin
    arst_n      = 1'b0;
    op_valid    = 1'b0;
    op          = '0;
    res_credit  = 1'b0;
    lcg_state   = 32'hf32e;
    n_built     = 0;
    tb_errors   = 0;
    credit_seen = 0;
    given       = 0;
    sent        = 0;
    up_credits  = rv_exec_pkg::OP_QUEUE_DEPTH;
    hold_left   = HOLD_CYCLES;
    cur         = default_op();

    cur.rs1 = 64'd5;
    cur.rs2 = 64'd7;
    add_test(64'd12, 64'h1004, 64'd12, 64'd0, 1'b0, 1'b0);
    cur.rs1    = 64'd5;
    cur.rs2    = 64'd7;
    cur.alu_op = rv_exec_pkg::SUB;
    add_test(64'hffff_ffff_ffff_fffe, 64'h1004, 64'hffff_ffff_ffff_fffe, 64'd0, 1'b0, 1'b0);
    cur.rs1    = 64'h8000_0000_0000_0010;
    cur.imm    = 64'd4;
    cur.b_sel  = rv_exec_pkg::B_IMM;
    cur.alu_op = rv_exec_pkg::SRA;
    add_test(64'hf800_0000_0000_0001, 64'h1004, 64'hf800_0000_0000_0001, 64'd0, 1'b0, 1'b0);
    cur.rs1    = 64'd1;
    cur.rs2    = 64'hffff_ffff_ffff_ffff;
    cur.alu_op = rv_exec_pkg::SLTU;
    add_test(64'd1, 64'h1004, 64'd1, 64'd0, 1'b0, 1'b0);
    cur.rs1     = 64'h1234_5678_7fff_ffff; // upper half ignored
    cur.rs2     = 64'd1;
    cur.word_op = 1'b1;
    add_test(64'hffff_ffff_8000_0000, 64'h1004, 64'hffff_ffff_8000_0000, 64'd0, 1'b0, 1'b0);
    cur.rs1    = 64'd9;
    cur.rs2    = 64'd9;
    cur.imm    = 64'h40;
    cur.alu_op = rv_exec_pkg::SUB;
    cur.branch = rv_exec_pkg::BR_EQ;
    add_test(64'd0, 64'h1040, 64'd0, 64'd0, 1'b0, 1'b0);
    cur.rs1    = 64'd9;
    cur.rs2    = 64'd8;
    cur.imm    = 64'h40;
    cur.alu_op = rv_exec_pkg::SUB;
    cur.branch = rv_exec_pkg::BR_EQ;
    add_test(64'd1, 64'h1004, 64'd1, 64'd0, 1'b0, 1'b0);
    cur.rs1    = 64'hffff_ffff_ffff_fffd; // -3 < 2 signed
    cur.rs2    = 64'd2;
    cur.imm    = 64'hffff_ffff_ffff_fff0;
    cur.alu_op = rv_exec_pkg::SLT;
    cur.branch = rv_exec_pkg::BR_LT;
    add_test(64'd1, 64'h0ff0, 64'd1, 64'd0, 1'b0, 1'b0);
    cur.a_sel_pc = 1'b1;
    cur.b_sel    = rv_exec_pkg::B_FOUR;
    cur.imm      = 64'h200;
    cur.branch   = rv_exec_pkg::BR_JAL;
    add_test(64'h1004, 64'h1200, 64'h1004, 64'd0, 1'b0, 1'b0);
    cur.a_sel_pc = 1'b1;
    cur.b_sel    = rv_exec_pkg::B_FOUR;
    cur.rs1      = 64'h2001;
    cur.imm      = 64'h10;
    cur.branch   = rv_exec_pkg::BR_JALR;
    add_test(64'h1004, 64'h2010, 64'h1004, 64'd0, 1'b0, 1'b0);
    cur.imm           = 64'h200;
    cur.branch        = rv_exec_pkg::BR_JAL;
    cur.sys_pc        = 64'h8000_0000;
    cur.sys_change_pc = 1'b1;
    cur.ebreak        = 1'b1;
    add_test(64'd0, 64'h8000_0000, 64'd0, 64'd0, 1'b1, 1'b0);
    cur.mem_to_reg = 1'b1;
    cur.mem_op     = rv_exec_pkg::LB;
    cur.rdata      = 64'h1122_3344_5566_7780;
    add_test(64'd0, 64'h1004, 64'hffff_ffff_ffff_ff80, 64'd0, 1'b0, 1'b0);
    cur.mem_to_reg = 1'b1;
    cur.mem_op     = rv_exec_pkg::LHU;
    cur.rdata      = 64'h1122_3344_5566_f00d;
    cur.rs1        = 64'h55;
    cur.csr_op     = rv_exec_pkg::CSR_RW;
    add_test(64'h55, 64'h1004, 64'h0000_0000_0000_f00d, 64'h55, 1'b0, 1'b0);
    cur.mem_to_reg = 1'b1;
    cur.mem_op     = rv_exec_pkg::LW;
    cur.rdata      = 64'h1111_2222_8000_0001;
    cur.rs1        = 64'h0f;
    cur.csr_rdata  = 64'hf0;
    cur.csr_op     = rv_exec_pkg::CSR_RS;
    cur.illegal    = 1'b1;
    add_test(64'h0f, 64'h1004, 64'hffff_ffff_8000_0001, 64'hff, 1'b0, 1'b1);
    cur.mem_to_reg = 1'b1;
    cur.mem_op     = rv_exec_pkg::LD;
    cur.rdata      = 64'hdead_beef_0123_4567;
    cur.rs1        = 64'd3;
    cur.csr_rdata  = 64'haa; // ignored without a csr op
    add_test(64'd3, 64'h1004, 64'hdead_beef_0123_4567, 64'd0, 1'b0, 1'b0);
    cur.rs1     = 64'd1;
    cur.rs2     = 64'hcafe;
    cur.sel_csr = 1'b1;
    add_test(64'hcaff, 64'h1004, 64'hcafe, 64'd0, 1'b0, 1'b0);

    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    while (sent < N_TESTS) begin
      tick();
      op_valid = 1'b0;
      if (up_credits > 0) begin
        op       = ops[sent];
        op_valid = 1'b1;
        up_credits--;
        sent++;
      end
    end
    while (n_seen < N_TESTS) begin
      tick();
      op_valid = 1'b0;
    end
    repeat (4) tick(); // room for a stray extra result

    if (n_seen != N_TESTS) begin
      $display("FAIL %0t results expected %0d actual %0d", $time, N_TESTS, n_seen);
      tb_errors++;
    end
    $display("results %0d of %0d, passed %0d, failed %0d, other errors %0d",
             n_seen, N_TESTS, n_pass, n_fail, tb_errors);
    if (n_fail == 0 && tb_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_rv_exec_asserts.sv
// credit and ordering assertions for the execute stage, bound into the top level by the testbench
`timescale 1ns/1ps
`default_nettype none

module rv_exec_asserts (
  input wire                         i_clk,
  input wire                         i_arst_n,
  input wire                         i_op_valid,
  input wire                         i_op_credit,
  input wire                         i_res_credit,
  input wire                         i_res_valid,
  input wire rv_exec_pkg::exec_res_t i_res
);

  int                owed; // downstream credits not yet spent by a result
  int                fill; // ops accepted and not yet popped
  rv_exec_pkg::tag_t last_tag;

  always @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      owed     <= 0;
      fill     <= 0;
      last_tag <= '1; // so the first result carries tag 0
    end else begin
      owed <= owed + int'(i_res_credit) - int'(i_res_valid);
      fill <= fill + int'(i_op_valid) - int'(i_op_credit);
      if (i_res_valid) begin
        last_tag <= i_res.tag;
      end
    end
  end

  assert property (@(posedge i_clk) disable iff (!i_arst_n) i_res_valid |-> owed > 0)
    else $error("result sent without a downstream credit");

  assert property (@(posedge i_clk) disable iff (!i_arst_n)
                   i_op_valid |-> fill < rv_exec_pkg::OP_QUEUE_DEPTH)
    else $error("operation sent while the queue is full");

  assert property (@(posedge i_clk) disable iff (!i_arst_n)
                   i_res_valid |-> i_res.tag == rv_exec_pkg::tag_t'(last_tag + 1'b1))
    else $error("result tag out of sequence");

endmodule

bind rv_exec_top rv_exec_asserts u_asserts (
  .i_clk       (i_clk),
  .i_arst_n    (i_arst_n),
  .i_op_valid  (i_op_valid),
  .i_op_credit (o_op_credit),
  .i_res_credit(i_res_credit),
  .i_res_valid (o_res_valid),
  .i_res       (o_res)
);

`default_nettype wire
